// ==== flist.f ====
+incdir+common
common/rcc_reg_pkg.sv
common/rcc_access_pkg.sv
common/rsr_if.sv
src/rst_src_sync.sv
rsr/rsr_flags.sv
src/rcc_reg_access.sv
src/rcc_vdd_reg.sv
dv/rcc_vdd_reg_sva.sv
dv/rcc_checker.sv
dv/tb_rcc_vdd_reg.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f flist.f --top-module tb_rcc_vdd_reg
out=$(./obj_dir/Vtb_rcc_vdd_reg)
echo "$out"
echo "$out" | grep -qx "TESTS PASSED"

// ==== dv/tb_rcc_vdd_reg.sv ====
`include "rcc_consts.svh"

module tb_rcc_vdd_reg;

  logic                    clk = 1'b0;
  logic                    rst, lsi_rdy, req, op, ack;
  logic [`RCC_NUM_SRC-1:0] rst_src;
  logic [1:0]              addr;
  logic [`RCC_DATA_W-1:0]  wdata, rdata;
  int                      err_count, read_count, total_err;
  int                      test_num, errs_mark, reads_mark;
  integer                  seed;
  logic [31:0]             rnd;
  // set once an access times out
  bit                      hung;

  always #4 clk = ~clk;

  rcc_vdd_reg rcc_vdd_reg_i (
    .clk(clk), .rst(rst), .rst_src(rst_src), .lsi_rdy(lsi_rdy), .req(req), .op(op),
    .addr(addr), .wdata(wdata), .ack(ack), .rdata(rdata)
  );

  rcc_checker chk_i (
    .clk(clk), .rst(rst), .rst_src(rst_src), .lsi_rdy(lsi_rdy), .req(req), .op(op),
    .addr(addr), .wdata(wdata), .ack(ack), .rdata(rdata),
    .err_count(err_count), .read_count(read_count)
  );

  // ------------------------------
  // stimulus tasks
  // ------------------------------
  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic report_hang(input string what, input rcc_access_pkg::acc_op_e kind,
                             input rcc_reg_pkg::reg_addr_e a);
    $display("timeout: ack did not %s within 20 cycles on %s of %s",
             what, kind.name(), a.name());
    hung = 1'b1;
  endtask

  // full four-phase cycle starting on a falling edge
  task automatic do_access(input rcc_access_pkg::acc_op_e kind,
                           input rcc_reg_pkg::reg_addr_e a, input logic [31:0] data);
    int waited;
    if (!hung) begin
      req   = 1'b1;
      op    = kind;
      addr  = a;
      wdata = data;
      waited = 0;
      while (!ack && waited < 20) begin
        @(negedge clk);
        waited++;
      end
      if (!ack) begin
        report_hang("rise", kind, a);
      end else begin
        req = 1'b0;
        waited = 0;
        while (ack && waited < 20) begin
          @(negedge clk);
          waited++;
        end
        if (ack) begin
          report_hang("fall", kind, a);
        end
      end
    end
  endtask

  task automatic pulse_sources(input logic [`RCC_NUM_SRC-1:0] pattern);
    rst_src = pattern;
    idle_cycles(6);
    rst_src = '0;
    idle_cycles(6);
  endtask

  task automatic close_test(input string name);
    test_num++;
    $display("test %0d %s: %0d reads, %0d errors", test_num, name,
             read_count - reads_mark, err_count - errs_mark);
    reads_mark = read_count;
    errs_mark  = err_count;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    seed = 32'h5c27;
    {rst, lsi_rdy, req, op, addr, wdata, rst_src} = '0;
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // power-on style flags only
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C1, '0);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C2, '0);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_CSR, '0);
    close_test("reset values");
    repeat (4) begin
      rnd = $random(seed);
      pulse_sources(rnd[`RCC_NUM_SRC-1:0]);
      do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C1, '0);
      do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C2, '0);
    end
    close_test("sticky capture");
    do_access(rcc_access_pkg::OP_WRITE, rcc_reg_pkg::ADDR_RSR_C1, 32'd1 << `RCC_RMVF_BIT);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C1, '0);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C2, '0);
    do_access(rcc_access_pkg::OP_WRITE, rcc_reg_pkg::ADDR_RSR_C1, '0);
    rnd = $random(seed);
    pulse_sources(rnd[`RCC_NUM_SRC-1:0]);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C1, '0);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C2, '0);
    close_test("per-core clear");
    // sources held high through the clear
    do_access(rcc_access_pkg::OP_WRITE, rcc_reg_pkg::ADDR_RSR_C2, 32'd1 << `RCC_RMVF_BIT);
    rst_src = '1;
    idle_cycles(6);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C2, '0);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C1, '0);
    rst_src = '0;
    do_access(rcc_access_pkg::OP_WRITE, rcc_reg_pkg::ADDR_RSR_C2, '0);
    idle_cycles(6);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C2, '0);
    close_test("clear dominance");
    do_access(rcc_access_pkg::OP_WRITE, rcc_reg_pkg::ADDR_CSR, 32'h1);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_CSR, '0);
    lsi_rdy = 1'b1;
    idle_cycles(6);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_CSR, '0);
    // clears lsion while lsirdy and the rest stay read only
    do_access(rcc_access_pkg::OP_WRITE, rcc_reg_pkg::ADDR_CSR, 32'hffff_fffe);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_CSR, '0);
    do_access(rcc_access_pkg::OP_WRITE, rcc_reg_pkg::ADDR_NONE, '1);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_NONE, '0);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_CSR, '0);
    // unmapped write must not reach either rsr
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C1, '0);
    do_access(rcc_access_pkg::OP_READ, rcc_reg_pkg::ADDR_RSR_C2, '0);
    close_test("csr");
    rnd = $random(seed);
    rst_src = rnd[`RCC_NUM_SRC-1:0];
    repeat (8) begin
      rnd = $random(seed);
      do_access(rcc_access_pkg::acc_op_e'(rnd[0]), rcc_reg_pkg::reg_addr_e'(rnd[2:1]), rnd);
    end
    close_test("back-to-back");
    total_err = err_count + rcc_vdd_reg_i.u_rcc_reg_access.sva_i.fail_count;
    $display("%0d tests, %0d reads checked, %0d errors", test_num, read_count, total_err);
    if (total_err == 0 && read_count > 0 && !hung) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/rcc_checker.sv ====
`include "rcc_consts.svh"

module rcc_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`RCC_NUM_SRC-1:0] rst_src,
  input  logic                    lsi_rdy,
  input  logic                    req,
  input  logic                    op,
  input  logic [1:0]              addr,
  input  logic [`RCC_DATA_W-1:0]  wdata,
  input  logic                    ack,
  input  logic [`RCC_DATA_W-1:0]  rdata,
  output int                      err_count,
  output int                      read_count
);

  // model of both status registers and the csr
  logic [`RCC_NUM_SRC-1:0] flags_c1, flags_c2;
  logic                    rmvf_c1, rmvf_c2, nxt_rmvf_c1, nxt_rmvf_c2;
  logic                    lsion_m;
  // two-cycle input latency with a as the newer sample
  logic [`RCC_NUM_SRC-1:0] src_a, src_b;
  logic                    lsi_a, lsi_b;
  // handshake tracking
  logic                    pend, cmp_due;
  logic [`RCC_DATA_W-1:0]  cmp_exp;
  rcc_reg_pkg::reg_addr_e  addr_e, cmp_addr;

  assign addr_e = rcc_reg_pkg::reg_addr_e'(addr);

  // por, pin, bor, d2 and d1 are set out of reset
  function automatic logic [`RCC_NUM_SRC-1:0] reset_flags();
    logic [`RCC_NUM_SRC-1:0] f;
    f = '0;
    f[rcc_reg_pkg::FLAG_POR] = 1'b1;
    f[rcc_reg_pkg::FLAG_PIN] = 1'b1;
    f[rcc_reg_pkg::FLAG_BOR] = 1'b1;
    f[rcc_reg_pkg::FLAG_D2]  = 1'b1;
    f[rcc_reg_pkg::FLAG_D1]  = 1'b1;
    return f;
  endfunction

  // obl sits under the reserved bit and the rest count down from bit 31
  function automatic int flag_bit_pos(input int idx);
    if (idx == int'(rcc_reg_pkg::FLAG_OBL)) begin
      return `RCC_OBL_BIT;
    end
    return `RCC_FLAG_MSB - idx;
  endfunction

  // ------------------------------
  // reference read image
  // ------------------------------
  function automatic logic [`RCC_DATA_W-1:0] expected_read(input rcc_reg_pkg::reg_addr_e a);
    logic [`RCC_DATA_W-1:0]  img;
    logic [`RCC_NUM_SRC-1:0] f;
    img = '0;
    f = (a == rcc_reg_pkg::ADDR_RSR_C1) ? flags_c1 : flags_c2;
    case (a)
      rcc_reg_pkg::ADDR_RSR_C1, rcc_reg_pkg::ADDR_RSR_C2: begin
        for (int i = 0; i < `RCC_NUM_SRC; i++) begin
          img[flag_bit_pos(i)] = f[i];
        end
        img[`RCC_RMVF_BIT] = (a == rcc_reg_pkg::ADDR_RSR_C1) ? rmvf_c1 : rmvf_c2;
      end
      rcc_reg_pkg::ADDR_CSR: begin
        img[`RCC_LSION_BIT]  = lsion_m;
        img[`RCC_LSIRDY_BIT] = lsi_b;
      end
      default: img = '0;
    endcase
    return img;
  endfunction

  // ------------------------------
  // model update and compare
  // ------------------------------
  always @(posedge clk) begin
    if (rst) begin
      flags_c1 = reset_flags();
      flags_c2 = reset_flags();
      {rmvf_c1, rmvf_c2, lsion_m, lsi_a, lsi_b, pend, cmp_due} = '0;
      src_a = '0;
      src_b = '0;
    end else begin
      // rdata was loaded on the ack edge and is checked one edge later
      if (cmp_due && (rdata !== cmp_exp)) begin
        err_count++;
        $display("Error at %0t: read of %s gave %h, expected %h",
                 $time, cmp_addr.name(), rdata, cmp_exp);
      end
      cmp_due = 1'b0;
      nxt_rmvf_c1 = rmvf_c1;
      nxt_rmvf_c2 = rmvf_c2;
      // edge after req is seen is the one where ack rises
      if (pend) begin
        pend = 1'b0;
        if (op == rcc_access_pkg::OP_READ) begin
          cmp_exp  = expected_read(addr_e);
          cmp_addr = addr_e;
          cmp_due  = 1'b1;
          read_count++;
        end else begin
          case (addr_e)
            rcc_reg_pkg::ADDR_RSR_C1: nxt_rmvf_c1 = wdata[`RCC_RMVF_BIT];
            rcc_reg_pkg::ADDR_RSR_C2: nxt_rmvf_c2 = wdata[`RCC_RMVF_BIT];
            rcc_reg_pkg::ADDR_CSR:    lsion_m = wdata[`RCC_LSION_BIT];
            default: ;
          endcase
        end
      end else if (req && !ack) begin
        pend = 1'b1;
      end
      // clear wins over set
      flags_c1 = rmvf_c1 ? '0 : (flags_c1 | src_b);
      flags_c2 = rmvf_c2 ? '0 : (flags_c2 | src_b);
      rmvf_c1  = nxt_rmvf_c1;
      rmvf_c2  = nxt_rmvf_c2;
      src_b = src_a;
      src_a = rst_src;
      lsi_b = lsi_a;
      lsi_a = lsi_rdy;
    end
  end

endmodule

// ==== dv/rcc_vdd_reg_sva.sv ====
// handshake checks bound into rcc_reg_access
module rcc_vdd_reg_sva (
  input logic                       clk,
  input logic                       rst,
  input logic                       req,
  input logic                       ack,
  input rcc_access_pkg::acc_state_e state
);

  // bumped by any failing property
  int fail_count;

  // ------------------------------
  // reset and four-phase rules
  // ------------------------------
  // fsm back in idle with ack low once rst has been seen
  a_ack_low_after_rst: assert property (@(posedge clk)
    rst |=> (!ack && (state == rcc_access_pkg::IDLE)))
    else begin
      $error("ack high or fsm not idle in the cycle after rst");
      fail_count++;
    end

  // idle with req low stays idle
  a_no_rise_without_req: assert property (@(posedge clk) disable iff (rst)
    (!ack && !req) |=> !ack)
    else begin
      $error("ack rose while req was low");
      fail_count++;
    end

  // ack held until the master lets go
  a_ack_held: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
    else begin
      $error("ack dropped while req was still high");
      fail_count++;
    end

endmodule

bind rcc_reg_access rcc_vdd_reg_sva sva_i (
  .clk   (clk),
  .rst   (rst),
  .req   (req),
  .ack   (ack),
  .state (state)
);

// ==== src/rcc_vdd_reg.sv ====
`include "rcc_consts.svh"

module rcc_vdd_reg (
  input  logic                    clk,
  input  logic                    rst,
  // async reset causes, level high
  input  logic [`RCC_NUM_SRC-1:0] rst_src,
  input  logic                    lsi_rdy,
  // four-phase register port
  input  logic                    req,
  input  logic                    op,
  input  logic [1:0]              addr,
  input  logic [`RCC_DATA_W-1:0]  wdata,
  output logic                    ack,
  output logic [`RCC_DATA_W-1:0]  rdata
);

  // per-core status register links
  rsr_if rsr_c1_if ();
  rsr_if rsr_c2_if ();

  logic lsirdy_sync;

  // ------------------------------
  // input side
  // ------------------------------
  rst_src_sync u_rst_src_sync (
    .clk         (clk),
    .rst         (rst),
    .rst_src     (rst_src),
    .lsi_rdy     (lsi_rdy),
    .c1          (rsr_c1_if.src),
    .c2          (rsr_c2_if.src),
    .lsirdy_sync (lsirdy_sync)
  );

  // ------------------------------
  // status registers
  // ------------------------------
  rsr_flags u_rsr_c1 (.clk(clk), .rst(rst), .bus(rsr_c1_if.rsr));
  rsr_flags u_rsr_c2 (.clk(clk), .rst(rst), .bus(rsr_c2_if.rsr));

  // register port, csr and read path
  rcc_reg_access u_rcc_reg_access (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .op          (op),
    .addr        (addr),
    .wdata       (wdata),
    .ack         (ack),
    .rdata       (rdata),
    .lsirdy_sync (lsirdy_sync),
    .c1          (rsr_c1_if.acc),
    .c2          (rsr_c2_if.acc)
  );

endmodule

// ==== src/rcc_reg_access.sv ====
`include "rcc_consts.svh"

module rcc_reg_access (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req,
  input  logic                   op,
  input  logic [1:0]             addr,
  input  logic [`RCC_DATA_W-1:0] wdata,
  output logic                   ack,
  output logic [`RCC_DATA_W-1:0] rdata,
  input  logic                   lsirdy_sync,
  rsr_if.acc                     c1,
  rsr_if.acc                     c2
);

  rcc_access_pkg::acc_state_e state, state_nxt;
  rcc_access_pkg::acc_op_e    op_dec;
  rcc_reg_pkg::reg_addr_e     addr_dec;
  logic                       wr_en;
  logic                       lsion;
  logic [`RCC_DATA_W-1:0]     rd_mux;

  assign op_dec   = rcc_access_pkg::acc_op_e'(op);
  assign addr_dec = rcc_reg_pkg::reg_addr_e'(addr);

  // ------------------------------
  // handshake fsm
  // ------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      rcc_access_pkg::IDLE:    if (req) state_nxt = rcc_access_pkg::ACCESS;
      rcc_access_pkg::ACCESS:  state_nxt = rcc_access_pkg::ACK;
      // hold ack until master lets go
      rcc_access_pkg::ACK:     if (!req) state_nxt = rcc_access_pkg::RELEASE;
      rcc_access_pkg::RELEASE: state_nxt = rcc_access_pkg::IDLE;
      default:                 state_nxt = rcc_access_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rcc_access_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign ack = (state == rcc_access_pkg::ACK) || (state == rcc_access_pkg::RELEASE);

  // ------------------------------
  // write decode
  // ------------------------------
  // strobe lands on the edge where ack rises
  assign wr_en       = (state == rcc_access_pkg::ACCESS) && (op_dec == rcc_access_pkg::OP_WRITE);
  assign c1.rmvf_wr  = wr_en && (addr_dec == rcc_reg_pkg::ADDR_RSR_C1);
  assign c2.rmvf_wr  = wr_en && (addr_dec == rcc_reg_pkg::ADDR_RSR_C2);
  assign c1.rmvf_val = wdata[`RCC_RMVF_BIT];
  assign c2.rmvf_val = wdata[`RCC_RMVF_BIT];

  // csr oscillator enable, lsirdy is read only
  always_ff @(posedge clk) begin
    if (rst) begin
      lsion <= 1'b0;
    end else if (wr_en && (addr_dec == rcc_reg_pkg::ADDR_CSR)) begin
      lsion <= wdata[`RCC_LSION_BIT];
    end
  end

  // ------------------------------
  // read mux
  // ------------------------------
  always_comb begin
    rd_mux = '0;
    case (addr_dec)
      rcc_reg_pkg::ADDR_RSR_C1: rd_mux = c1.rsr_val;
      rcc_reg_pkg::ADDR_RSR_C2: rd_mux = c2.rsr_val;
      rcc_reg_pkg::ADDR_CSR: begin
        rd_mux[`RCC_LSION_BIT]  = lsion;
        rd_mux[`RCC_LSIRDY_BIT] = lsirdy_sync;
      end
      // unmapped reads 0
      default:                  rd_mux = '0;
    endcase
  end

  // captured once, held through ack
  always_ff @(posedge clk) begin
    if (state == rcc_access_pkg::ACCESS) begin
      rdata <= rd_mux;
    end
  end

endmodule

// ==== rsr/rsr_flags.sv ====
`include "rcc_consts.svh"

module rsr_flags (
  input  logic clk,
  input  logic rst,
  rsr_if.rsr   bus
);

  // sticky flags, indexed by flag_idx_e
  logic [`RCC_NUM_SRC-1:0] flags;
  // remove-flag bit
  logic                    rmvf;

  // ------------------------------
  // flag and rmvf storage
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      // power-on style causes read 1
      flags <= `RCC_FLAG_RST_MASK;
      rmvf  <= 1'b0;
    end else begin
      if (bus.rmvf_wr) begin
        rmvf <= bus.rmvf_val;
      end
      // clear beats set while rmvf is held
      if (rmvf) begin
        flags <= '0;
      end else begin
        flags <= flags | bus.src_sync;
      end
    end
  end

  // ------------------------------
  // register image
  // ------------------------------
  always_comb begin
    bus.rsr_val = '0;
    // lpwr2 .. d1 packed down from the msb
    for (int i = 0; i < int'(rcc_reg_pkg::FLAG_OBL); i++) begin
      bus.rsr_val[`RCC_FLAG_MSB - i] = flags[i];
    end
    // bit 18 left reserved, obl below it
    bus.rsr_val[`RCC_OBL_BIT]  = flags[rcc_reg_pkg::FLAG_OBL];
    bus.rsr_val[`RCC_RMVF_BIT] = rmvf;
  end

endmodule

// ==== src/rst_src_sync.sv ====
`include "rcc_consts.svh"

module rst_src_sync (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`RCC_NUM_SRC-1:0] rst_src,
  input  logic                    lsi_rdy,
  rsr_if.src                      c1,
  rsr_if.src                      c2,
  output logic                    lsirdy_sync
);

  // ------------------------------
  // sync chains
  // ------------------------------
  // lsi_rdy rides along as the top bit
  logic [`RCC_SYNC_STAGES-1:0][`RCC_NUM_SRC:0] sync_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      sync_q <= '0;
    end else begin
      // first stage samples async levels
      sync_q[0] <= {lsi_rdy, rst_src};
      for (int s = 1; s < `RCC_SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  // ------------------------------
  // fan-out
  // ------------------------------
  // both cores see the same sources
  assign c1.src_sync  = sync_q[`RCC_SYNC_STAGES-1][`RCC_NUM_SRC-1:0];
  assign c2.src_sync  = sync_q[`RCC_SYNC_STAGES-1][`RCC_NUM_SRC-1:0];
  // csr ready bit
  assign lsirdy_sync  = sync_q[`RCC_SYNC_STAGES-1][`RCC_NUM_SRC];

endmodule

// ==== common/rsr_if.sv ====
`include "rcc_consts.svh"

// one instance per core status register
interface rsr_if;

  // synchronized reset sources
  logic [`RCC_NUM_SRC-1:0] src_sync;
  // single-cycle rmvf write strobe and its value
  logic                    rmvf_wr;
  logic                    rmvf_val;
  // full register image back to the read mux
  logic [`RCC_DATA_W-1:0]  rsr_val;

  // synchronizer side
  modport src (output src_sync);

  // flag storage
  modport rsr (input src_sync, input rmvf_wr, input rmvf_val, output rsr_val);

  // register access side
  modport acc (output rmvf_wr, output rmvf_val, input rsr_val);

endinterface

// ==== common/rcc_access_pkg.sv ====
package rcc_access_pkg;

  // access direction, sampled with req
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } acc_op_e;

  // ------------------------------
  // four-phase handshake
  // ------------------------------
  // ack is high in ACK and RELEASE
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ACCESS  = 2'd1,
    ACK     = 2'd2,
    RELEASE = 2'd3
  } acc_state_e;

endpackage

// ==== common/rcc_reg_pkg.sv ====
package rcc_reg_pkg;

  // ------------------------------
  // register map
  // ------------------------------
  // one code per register, top code maps to nothing
  typedef enum logic [1:0] {
    ADDR_RSR_C1 = 2'd0,
    ADDR_RSR_C2 = 2'd1,
    ADDR_CSR    = 2'd2,
    ADDR_NONE   = 2'd3
  } reg_addr_e;

  // ------------------------------
  // source / flag index
  // ------------------------------
  // same order as the rsr bit layout, msb first
  // obl comes last, it sits below the reserved bit
  typedef enum logic [3:0] {
    FLAG_LPWR2 = 4'd0,
    FLAG_LPWR1 = 4'd1,
    FLAG_WWDG2 = 4'd2,
    FLAG_WWDG1 = 4'd3,
    FLAG_IWDG2 = 4'd4,
    FLAG_IWDG1 = 4'd5,
    FLAG_SFT2  = 4'd6,
    FLAG_SFT1  = 4'd7,
    FLAG_POR   = 4'd8,
    FLAG_PIN   = 4'd9,
    FLAG_BOR   = 4'd10,
    FLAG_D2    = 4'd11,
    FLAG_D1    = 4'd12,
    FLAG_OBL   = 4'd13
  } flag_idx_e;

endpackage

// ==== common/rcc_consts.svh ====
`ifndef RCC_CONSTS_SVH
`define RCC_CONSTS_SVH

// ------------------------------
// sizes
// ------------------------------
// reset sources feeding each rsr
`define RCC_NUM_SRC 14
// register data bus
`define RCC_DATA_W 32
// flops per synchronizer chain
`define RCC_SYNC_STAGES 2

// ------------------------------
// bit positions
// ------------------------------
// lpwr2 on top, flags run downward to d1
`define RCC_FLAG_MSB 31
`define RCC_OBL_BIT 17
`define RCC_RMVF_BIT 16
// csr fields
`define RCC_LSION_BIT 0
`define RCC_LSIRDY_BIT 1

// por, pin, bor, d2, d1 read 1 out of reset
`define RCC_FLAG_RST_MASK 14'h1f00

`endif
